// ==== common/mem_arb_macros.svh ====
`ifndef MEM_ARB_MACROS_SVH
`define MEM_ARB_MACROS_SVH

// data word width of the RAM and both cache ports
`define MEM_WORD_W 32

// word-address bits, RAM holds 2**RAM_ADDR_W words
`define RAM_ADDR_W 8

// cycles from access start up to and including ACCESS
`define RAM_LATENCY 2

// rows per scratchpad load
`define SP_ROWS 4

// byte distance between rows in memory
`define SP_ROW_STRIDE 16

// high word of a row sits this many bytes above the low word
`define SP_HALF_STRIDE 8

`endif

// ==== common/mem_arb_pkg.sv ====
`default_nettype none

`include "mem_arb_macros.svh"

package mem_arb_pkg;

  typedef enum logic [1:0] {
    FREE   = 2'b00,
    BUSY   = 2'b01,
    ACCESS = 2'b10
  } ram_state_e;

  typedef struct packed {
    logic [31:0]             addr;
    logic [`MEM_WORD_W-1:0]  store;
    logic                    ren;
    logic                    wen;
  } ram_req_t;

  typedef struct packed {
    logic [`MEM_WORD_W-1:0]  load;
    ram_state_e              state;
  } ram_rsp_t;

  // shared by dcache and icache, icache leaves wen low
  typedef struct packed {
    logic                    ren;
    logic                    wen;
    logic [31:0]             addr;
    logic [`MEM_WORD_W-1:0]  store;
  } cache_req_t;

  // load is valid in the cycle waiting drops
  typedef struct packed {
    logic                    waiting;
    logic [`MEM_WORD_W-1:0]  load;
  } cache_rsp_t;

  typedef struct packed {
    logic                      load;
    logic                      store;
    logic [31:0]               load_addr;
    logic [31:0]               store_addr;
    logic [2*`MEM_WORD_W-1:0]  store_data;
  } sp_req_t;

  typedef struct packed {
    logic                      load_hit;
    logic                      store_hit;
    logic [2*`MEM_WORD_W-1:0]  load_data;
  } sp_rsp_t;

endpackage

`default_nettype wire

// ==== design/shared_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_arb_macros.svh"

module shared_ram import mem_arb_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  ram_req_t ram_req,
  output ram_rsp_t ram_rsp
);

  localparam int CNT_W = ($clog2(`RAM_LATENCY) > 0) ? $clog2(`RAM_LATENCY) : 1;

  logic [`MEM_WORD_W-1:0] mem [2**`RAM_ADDR_W];

  logic [`RAM_ADDR_W-1:0] word_idx;
  logic [CNT_W-1:0]       cnt, cnt_cur;
  logic [31:0]            last_addr;
  logic                   last_wen;
  logic                   prev_busy;
  logic                   active;
  logic                   restart;
  ram_state_e             state;

  // byte address, word aligned
  assign word_idx = ram_req.addr[`RAM_ADDR_W+1:2];
  assign active   = ram_req.ren || ram_req.wen;

  // a new access unless the same request was already counting
  assign restart = !prev_busy
                || (ram_req.addr != last_addr)
                || (ram_req.wen != last_wen);

  assign cnt_cur = restart ? '0 : cnt;

  always_comb begin
    if (!active) begin
      state = FREE;
    end else if (cnt_cur == CNT_W'(`RAM_LATENCY - 1)) begin
      state = ACCESS;
    end else begin
      state = BUSY;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt       <= '0;
      prev_busy <= 1'b0;
      last_addr <= '0;
      last_wen  <= 1'b0;
    end else begin
      cnt       <= cnt_cur + CNT_W'(1);
      prev_busy <= (state == BUSY);
      last_addr <= ram_req.addr;
      last_wen  <= ram_req.wen;
    end
  end

  // write lands at the end of the ACCESS cycle
  always_ff @(posedge CLK) begin
    if (ram_req.wen && state == ACCESS) begin
      mem[word_idx] <= ram_req.store;
    end
  end

  assign ram_rsp.load  = mem[word_idx];
  assign ram_rsp.state = state;

endmodule

`default_nettype wire

// ==== design/scratchpad_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_arb_macros.svh"

module scratchpad_buffer import mem_arb_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        load_start,
  input  logic        store_start,
  input  logic [31:0] base_addr,
  input  logic [1:0]  store_row,
  output logic        load_done,
  output logic        store_done,
  input  logic [1:0]  row_sel,
  output logic [63:0] row_data,
  output sp_req_t     sp_req,
  input  sp_rsp_t     sp_rsp
);

  logic [2*`MEM_WORD_W-1:0] rows [`SP_ROWS];

  logic        load_pend;
  logic        store_pend;
  logic        busy;
  logic        start;
  logic        last_row;
  logic        row_hit;
  logic [1:0]  fill_idx;
  logic [1:0]  st_row_q;
  logic [31:0] addr_q;

  assign busy     = load_pend || store_pend;
  assign start    = !busy && (load_start || store_start);
  assign last_row = (fill_idx == 2'(`SP_ROWS - 1));
  assign row_hit  = load_pend && sp_rsp.load_hit;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      load_pend  <= 1'b0;
      store_pend <= 1'b0;
      fill_idx   <= '0;
      load_done  <= 1'b0;
      store_done <= 1'b0;
    end else begin
      load_done  <= 1'b0;
      store_done <= 1'b0;

      // load wins if both starts arrive together
      if (!busy) begin
        if (load_start) begin
          load_pend <= 1'b1;
          fill_idx  <= '0;
        end else if (store_start) begin
          store_pend <= 1'b1;
        end
      end

      if (row_hit) begin
        fill_idx <= fill_idx + 2'd1;
        if (last_row) begin
          load_pend <= 1'b0;
          load_done <= 1'b1;
        end
      end

      if (store_pend && sp_rsp.store_hit) begin
        store_pend <= 1'b0;
        store_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      addr_q   <= base_addr;
      st_row_q <= store_row;
    end
    if (row_hit) begin
      rows[fill_idx] <= sp_rsp.load_data;
    end
  end

  assign sp_req.load       = load_pend;
  assign sp_req.store      = store_pend;
  assign sp_req.load_addr  = addr_q;
  assign sp_req.store_addr = addr_q;
  assign sp_req.store_data = rows[st_row_q];

  assign row_data = rows[row_sel];

endmodule

`default_nettype wire

// ==== arbiter/memory_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_arb_macros.svh"

module memory_arbiter import mem_arb_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  sp_req_t    sp_req,
  output sp_rsp_t    sp_rsp,
  input  cache_req_t dreq,
  output cache_rsp_t drsp,
  input  cache_req_t ireq,
  output cache_rsp_t irsp,
  output ram_req_t   ram_req,
  input  ram_rsp_t   ram_rsp
);

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    SP_LOAD1  = 3'd1,
    SP_LOAD2  = 3'd2,
    SP_STORE1 = 3'd3,
    SP_STORE2 = 3'd4,
    DCACHE    = 3'd5,
    ICACHE    = 3'd6
  } arb_state_e;

  arb_state_e state, state_next;

  logic [1:0]  row, row_next;
  logic [31:0] row_base;
  logic        ram_done;
  logic        last_row;

  // low half of the row being fetched
  logic [`MEM_WORD_W-1:0] row_lo;

  assign ram_done = (ram_rsp.state == ACCESS);
  assign last_row = (row == 2'(`SP_ROWS - 1));
  assign row_base = sp_req.load_addr + 32'(row) * 32'(`SP_ROW_STRIDE);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      row   <= '0;
    end else begin
      state <= state_next;
      row   <= row_next;
    end
  end

  always_ff @(posedge CLK) begin
    if (state == SP_LOAD1 && ram_done) begin
      row_lo <= ram_rsp.load;
    end
  end

  // fixed priority, grant held until the transfer ends
  always_comb begin
    state_next = state;
    row_next   = row;
    case (state)
      IDLE: begin
        if (sp_req.load) begin
          state_next = SP_LOAD1;
          row_next   = '0;
        end else if (sp_req.store) begin
          state_next = SP_STORE1;
        end else if (dreq.ren || dreq.wen) begin
          state_next = DCACHE;
        end else if (ireq.ren) begin
          state_next = ICACHE;
        end
      end

      SP_LOAD1: begin
        if (ram_done) begin
          state_next = SP_LOAD2;
        end
      end

      SP_LOAD2: begin
        if (ram_done) begin
          if (last_row) begin
            state_next = IDLE;
            row_next   = '0;
          end else begin
            state_next = SP_LOAD1;
            row_next   = row + 2'd1;
          end
        end
      end

      SP_STORE1: begin
        if (ram_done) begin
          state_next = SP_STORE2;
        end
      end

      SP_STORE2: begin
        if (ram_done) begin
          state_next = IDLE;
        end
      end

      DCACHE: begin
        if (ram_done) begin
          state_next = IDLE;
        end
      end

      ICACHE: begin
        if (ram_done) begin
          state_next = IDLE;
        end
      end

      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_comb begin
    ram_req           = '0;
    sp_rsp.load_hit   = 1'b0;
    sp_rsp.store_hit  = 1'b0;
    // high word comes straight from the RAM in the hit cycle
    sp_rsp.load_data  = {ram_rsp.load, row_lo};
    drsp.waiting      = 1'b1;
    drsp.load         = ram_rsp.load;
    irsp.waiting      = 1'b1;
    irsp.load         = ram_rsp.load;

    case (state)
      SP_LOAD1: begin
        ram_req.addr = row_base;
        ram_req.ren  = 1'b1;
      end

      SP_LOAD2: begin
        ram_req.addr    = row_base + 32'(`SP_HALF_STRIDE);
        ram_req.ren     = 1'b1;
        sp_rsp.load_hit = ram_done;
      end

      SP_STORE1: begin
        ram_req.addr  = sp_req.store_addr;
        ram_req.store = sp_req.store_data[`MEM_WORD_W-1:0];
        ram_req.wen   = 1'b1;
      end

      SP_STORE2: begin
        ram_req.addr     = sp_req.store_addr + 32'(`SP_HALF_STRIDE);
        ram_req.store    = sp_req.store_data[2*`MEM_WORD_W-1:`MEM_WORD_W];
        ram_req.wen      = 1'b1;
        sp_rsp.store_hit = ram_done;
      end

      DCACHE: begin
        ram_req.addr  = dreq.addr;
        ram_req.store = dreq.store;
        ram_req.wen   = dreq.wen;
        ram_req.ren   = dreq.ren && !dreq.wen;
        drsp.waiting  = !ram_done;
      end

      ICACHE: begin
        ram_req.addr = ireq.addr;
        ram_req.ren  = ireq.ren;
        irsp.waiting = !ram_done;
      end

      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/mem_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem import mem_arb_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  cache_req_t  dreq,
  output cache_rsp_t  drsp,
  input  cache_req_t  ireq,
  output cache_rsp_t  irsp,
  input  logic        load_start,
  input  logic        store_start,
  input  logic [31:0] base_addr,
  input  logic [1:0]  store_row,
  output logic        load_done,
  output logic        store_done,
  input  logic [1:0]  row_sel,
  output logic [63:0] row_data
);

  sp_req_t  sp_req;
  sp_rsp_t  sp_rsp;
  ram_req_t ram_req;
  ram_rsp_t ram_rsp;

  scratchpad_buffer buffer_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .load_start  (load_start),
    .store_start (store_start),
    .base_addr   (base_addr),
    .store_row   (store_row),
    .load_done   (load_done),
    .store_done  (store_done),
    .row_sel     (row_sel),
    .row_data    (row_data),
    .sp_req      (sp_req),
    .sp_rsp      (sp_rsp)
  );

  // single owner of the RAM port
  memory_arbiter arbiter_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .sp_req  (sp_req),
    .sp_rsp  (sp_rsp),
    .dreq    (dreq),
    .drsp    (drsp),
    .ireq    (ireq),
    .irsp    (irsp),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

  shared_ram ram_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic CLK,
  output logic nRST
);

  localparam int PERIOD = 10;

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // two rising edges in reset, release between edges
  initial begin
    nRST = 1'b0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/tb_mem_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_arb_macros.svh"

module tb_mem_subsystem import mem_arb_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  localparam int MAX_WAIT   = 40;
  localparam int QUIET      = 4;
  localparam int WORST_OP   = 40;
  localparam int MARGIN     = 60;

  typedef enum logic [2:0] {
    OP_DWRITE, OP_DREAD, OP_IREAD, OP_DUAL,
    OP_SP_LOAD, OP_LOAD_DREAD, OP_SP_STORE, OP_ROW_CHECK
  } op_e;

  // addr2 is the icache address, the dcache address during a load, or a row index
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] addr2;
    logic [31:0] data;
    logic [63:0] exp_val;
  } entry_t;

  logic        CLK, nRST;
  cache_req_t  dreq, ireq;
  cache_rsp_t  drsp, irsp;
  logic        load_start, store_start;
  logic [31:0] base_addr;
  logic [1:0]  store_row, row_sel;
  logic        load_done, store_done;
  logic [63:0] row_data;

  entry_t      ops[$];
  logic [31:0] mirror [2**`RAM_ADDR_W];
  logic [63:0] sp_model [`SP_ROWS];
  logic [31:0] lcg_state;
  logic        table_ready = 1'b0;

  cache_rsp_t  d_got, i_got;
  int          d_cyc, i_cyc, done_cyc;
  int          load_pulses = 0;
  int          store_pulses = 0;
  int          err_value = 0;
  int          err_pulse = 0;
  int          err_order = 0;
  int          err_timeout = 0;

  tb_clock clock_inst (
    .CLK  (CLK),
    .nRST (nRST)
  );

  mem_subsystem mem_subsystem_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .dreq        (dreq),
    .drsp        (drsp),
    .ireq        (ireq),
    .irsp        (irsp),
    .load_start  (load_start),
    .store_start (store_start),
    .base_addr   (base_addr),
    .store_row   (store_row),
    .load_done   (load_done),
    .store_done  (store_done),
    .row_sel     (row_sel),
    .row_data    (row_data)
  );

  always @(negedge CLK) begin
    if (load_done) load_pulses <= load_pulses + 1;
    if (store_done) store_pulses <= store_pulses + 1;
  end

  initial begin
    int limit;
    wait (table_ready);
    limit = (ops.size() * WORST_OP + MARGIN) * CLK_PERIOD;
    #(limit);
    $display("watchdog expired: the test table did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // byte address to RAM word
  function automatic logic [`RAM_ADDR_W-1:0] widx(input logic [31:0] addr);
    return addr[`RAM_ADDR_W+1:2];
  endfunction

  function automatic void add_op(input op_e op, input logic [31:0] addr,
                                 input logic [31:0] addr2, input logic [31:0] data,
                                 input logic [63:0] exp_val);
    entry_t e;
    e.op      = op;
    e.addr    = addr;
    e.addr2   = addr2;
    e.data    = data;
    e.exp_val = exp_val;
    ops.push_back(e);
  endfunction

  function automatic void add_write(input logic [31:0] addr);
    logic [31:0] data;
    data = lcg_next();
    mirror[widx(addr)] = data;
    add_op(OP_DWRITE, addr, 32'h0, data, {32'h0, data});
  endfunction

  function automatic void add_read(input logic icache, input logic [31:0] addr);
    add_op(icache ? OP_IREAD : OP_DREAD, addr, 32'h0, 32'h0, {32'h0, mirror[widx(addr)]});
  endfunction

  function automatic void add_dual(input logic [31:0] daddr, input logic [31:0] iaddr);
    add_op(OP_DUAL, daddr, iaddr, 32'h0, {mirror[widx(iaddr)], mirror[widx(daddr)]});
  endfunction

  // rows are {high word, low word} at base + k*stride
  function automatic void add_load(input logic [31:0] base, input logic with_read,
                                   input logic [31:0] raddr);
    logic [31:0] lo_addr;
    for (int k = 0; k < `SP_ROWS; k++) begin
      lo_addr = base + 32'(k) * `SP_ROW_STRIDE;
      sp_model[2'(k)] = {mirror[widx(lo_addr + `SP_HALF_STRIDE)], mirror[widx(lo_addr)]};
    end
    if (with_read) begin
      add_op(OP_LOAD_DREAD, base, raddr, 32'h0, {32'h0, mirror[widx(raddr)]});
    end else begin
      add_op(OP_SP_LOAD, base, 32'h0, 32'h0, 64'h0);
    end
    for (int k = 0; k < `SP_ROWS; k++) begin
      add_op(OP_ROW_CHECK, 32'h0, 32'(k), 32'h0, sp_model[2'(k)]);
    end
  endfunction

  function automatic void add_store(input logic [1:0] row, input logic [31:0] addr);
    mirror[widx(addr)] = sp_model[row][31:0];
    mirror[widx(addr + `SP_HALF_STRIDE)] = sp_model[row][63:32];
    add_op(OP_SP_STORE, addr, 32'(row), 32'h0, sp_model[row]);
    add_read(1'b0, addr);
    add_read(1'b0, addr + `SP_HALF_STRIDE);
  endfunction

  function automatic void build_table();
    for (int j = 0; j < 4; j++) begin
      add_write(32'h040 + 32'(j) * 32'h24);
      add_read(1'b0, 32'h040 + 32'(j) * 32'h24);
    end
    // source rows for the first load
    for (int j = 0; j < 8; j++) add_write(32'h100 + 32'(j) * 32'h8);
    add_read(1'b1, 32'h108);
    add_read(1'b1, 32'h040);
    add_dual(32'h110, 32'h118);
    add_dual(32'h064, 32'h130);
    add_load(32'h100, 1'b0, 32'h0);
    add_store(2'd2, 32'h200);
    add_store(2'd0, 32'h280);
    // new source data, then reload with a dcache read queued behind it
    for (int j = 0; j < 8; j++) add_write(32'h100 + 32'(j) * 32'h8);
    add_load(32'h100, 1'b1, 32'h088);
    add_store(2'd3, 32'h2c0);
  endfunction

  task automatic check_word(input string name, input cache_rsp_t got,
                            input logic [31:0] exp);
    if (got.load !== exp) begin
      $display("error %s.load: got %h expected %h", name, got.load, exp);
      err_value++;
    end
  endtask

  task automatic check_row(input logic [1:0] idx, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("error row_data[%0d]: got %h expected %h", idx, got, exp);
      err_value++;
    end
  endtask

  task automatic check_pulses(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error %s pulses: got %h expected %h", name, got, exp);
      err_pulse++;
    end
  endtask

  // requests stay up through the edge that ends the access, then drop
  task automatic cache_transfer(input logic d_on, input cache_req_t d_rq,
                                input logic i_on, input cache_req_t i_rq);
    logic       d_pend, i_pend, d_hold, i_hold, d_low, i_low;
    cache_rsp_t d_now, i_now;
    int         cyc;
    d_pend   = d_on;
    i_pend   = i_on;
    d_hold   = 1'b0;
    i_hold   = 1'b0;
    d_cyc    = -1;
    i_cyc    = -1;
    done_cyc = -1;
    cyc      = 0;
    d_got    = '0;
    i_got    = '0;
    if (d_on) dreq = d_rq;
    if (i_on) ireq = i_rq;
    while ((d_pend || i_pend || d_hold || i_hold) && cyc < MAX_WAIT) begin
      @(negedge CLK);
      cyc++;
      d_now = drsp;
      i_now = irsp;
      d_low = !d_now.waiting;
      i_low = !i_now.waiting;
      if (load_done && done_cyc < 0) done_cyc = cyc;
      if (d_hold) begin
        dreq   = '0;
        d_hold = 1'b0;
      end else if (d_pend && d_low) begin
        d_got  = d_now;
        d_cyc  = cyc;
        d_pend = 1'b0;
        d_hold = 1'b1;
      end
      if (i_hold) begin
        ireq   = '0;
        i_hold = 1'b0;
      end else if (i_pend && i_low) begin
        i_got  = i_now;
        i_cyc  = cyc;
        i_pend = 1'b0;
        i_hold = 1'b1;
      end
    end
    if (d_pend || i_pend || d_hold || i_hold) begin
      $display("timeout: cache request at %h never saw wait go low",
               d_pend ? d_rq.addr : i_rq.addr);
      err_timeout++;
      dreq = '0;
      ireq = '0;
    end
  endtask

  task automatic pulse_start(input logic is_load, input logic [31:0] addr,
                             input logic [1:0] row);
    base_addr = addr;
    store_row = row;
    if (is_load) load_start = 1'b1;
    else store_start = 1'b1;
    @(negedge CLK);
    load_start  = 1'b0;
    store_start = 1'b0;
  endtask

  task automatic wait_pulse(input logic is_load);
    int   cyc;
    logic seen;
    cyc  = 0;
    seen = 1'b0;
    while (!seen && cyc < MAX_WAIT) begin
      @(negedge CLK);
      cyc++;
      seen = is_load ? load_done : store_done;
    end
    if (!seen) begin
      $display("timeout: %s never pulsed", is_load ? "load_done" : "store_done");
      err_timeout++;
    end
    repeat (QUIET) @(negedge CLK);
  endtask

  task automatic apply_op(input entry_t e);
    cache_req_t rq;
    cache_req_t iq;
    int         pulses0;
    rq      = '0;
    rq.addr = e.addr;
    iq      = '0;
    case (e.op)
      OP_DWRITE: begin
        rq.wen   = 1'b1;
        rq.store = e.data;
        cache_transfer(1'b1, rq, 1'b0, '0);
      end
      OP_DREAD: begin
        rq.ren = 1'b1;
        cache_transfer(1'b1, rq, 1'b0, '0);
        check_word("drsp", d_got, e.exp_val[31:0]);
      end
      OP_IREAD: begin
        rq.ren = 1'b1;
        cache_transfer(1'b0, '0, 1'b1, rq);
        check_word("irsp", i_got, e.exp_val[31:0]);
      end
      OP_DUAL: begin
        rq.ren  = 1'b1;
        iq.ren  = 1'b1;
        iq.addr = e.addr2;
        cache_transfer(1'b1, rq, 1'b1, iq);
        check_word("drsp", d_got, e.exp_val[31:0]);
        check_word("irsp", i_got, e.exp_val[63:32]);
        if (d_cyc >= 0 && i_cyc >= 0 && d_cyc >= i_cyc) begin
          $display("order: icache wait went low before dcache wait at %h", e.addr);
          err_order++;
        end
      end
      OP_SP_LOAD: begin
        pulses0 = load_pulses;
        pulse_start(1'b1, e.addr, 2'd0);
        wait_pulse(1'b1);
        check_pulses("load_done", load_pulses - pulses0, 1);
      end
      OP_LOAD_DREAD: begin
        pulses0 = load_pulses;
        pulse_start(1'b1, e.addr, 2'd0);
        @(negedge CLK);
        rq.addr = e.addr2;
        rq.ren  = 1'b1;
        cache_transfer(1'b1, rq, 1'b0, '0);
        check_word("drsp", d_got, e.exp_val[31:0]);
        if (d_cyc >= 0 && (done_cyc < 0 || done_cyc >= d_cyc)) begin
          $display("order: dcache read at %h finished before load_done", e.addr2);
          err_order++;
        end
        repeat (QUIET) @(negedge CLK);
        check_pulses("load_done", load_pulses - pulses0, 1);
      end
      OP_SP_STORE: begin
        pulses0 = store_pulses;
        pulse_start(1'b0, e.addr, e.addr2[1:0]);
        wait_pulse(1'b0);
        check_pulses("store_done", store_pulses - pulses0, 1);
      end
      OP_ROW_CHECK: begin
        row_sel = e.addr2[1:0];
        @(negedge CLK);
        check_row(row_sel, row_data, e.exp_val);
      end
      default: begin
        $display("table entry has an unknown operation");
        err_order++;
      end
    endcase
  endtask

  initial begin
    int total;
    dreq        = '0;
    ireq        = '0;
    load_start  = 1'b0;
    store_start = 1'b0;
    base_addr   = '0;
    store_row   = '0;
    row_sel     = '0;
    lcg_state   = 32'heaac;
    build_table();
    table_ready = 1'b1;
    wait (nRST == 1'b1);
    @(negedge CLK);
    for (int i = 0; i < ops.size(); i++) begin
      apply_op(ops[i]);
    end
    total = err_value + err_pulse + err_order + err_timeout;
    $display("errors: %0d total, %0d value, %0d pulse, %0d order, %0d timeout",
             total, err_value, err_pulse, err_order, err_timeout);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/mem_arb_pkg.sv
design/shared_ram.sv
design/scratchpad_buffer.sv
arbiter/memory_arbiter.sv
design/mem_subsystem.sv
sim/tb_clock.sv
sim/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --top-module tb_mem_subsystem \
  -f list.f

./obj_dir/Vtb_mem_subsystem > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run.sh: testbench reported a failure, see sim.log"
  exit 1
fi
echo "run.sh: testbench run complete, see sim.log"
